/* verilog/mtx_pkg.sv */
/*
  Matrix transpose engine shared definitions
  Fixed matrix and tile geometry, tile and config types,
  element opcodes and the APB register map
*/
package mtx_pkg;

  // Matrix geometry
  localparam int DATA_WIDTH       = 8;
  localparam int TOTAL_DIM        = 4;
  localparam int TILE_DIM         = 2;
  localparam int TILE_ELEMS       = TILE_DIM * TILE_DIM;
  localparam int TILE_GRID        = TOTAL_DIM / TILE_DIM;
  localparam int TILES_PER_MATRIX = TILE_GRID * TILE_GRID;

  // Column FIFOs hold one full column of tiles
  localparam int FIFO_DEPTH     = TILE_GRID;
  localparam int FIFO_PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

  // Tile position counters
  localparam int GRID_CNT_WIDTH = (TILE_GRID > 1) ? $clog2(TILE_GRID) : 1;
  localparam logic [GRID_CNT_WIDTH-1:0] GRID_LAST = GRID_CNT_WIDTH'(TILE_GRID - 1);
  localparam int TILE_IDX_WIDTH = $clog2(TILES_PER_MATRIX);

  // Status counters
  localparam int STAT_WIDTH = 16;

  typedef logic signed [DATA_WIDTH-1:0] elem_t;

  localparam elem_t ELEM_MAX = elem_t'(2 ** (DATA_WIDTH - 1) - 1);
  localparam elem_t ELEM_MIN = elem_t'(-(2 ** (DATA_WIDTH - 1)));

  // One tile, row-major, element 0 in the low bits
  typedef struct packed {
    elem_t [TILE_ELEMS-1:0] e;
  } tile_t;

  typedef enum logic [1:0] {
    OP_PASS = 2'd0,
    OP_NEG  = 2'd1,
    OP_SHR  = 2'd2,
    OP_ABS  = 2'd3
  } elem_op_e;

  localparam int SHAMT_WIDTH = 3;

  typedef struct packed {
    elem_op_e                op;
    logic [SHAMT_WIDTH-1:0]  shamt;
  } elem_cfg_t;

  // APB register map
  localparam int APB_ADDR_WIDTH = 4;
  localparam int APB_DATA_WIDTH = 32;

  localparam logic [APB_ADDR_WIDTH-1:0] ADDR_CTRL     = 4'h0;
  localparam logic [APB_ADDR_WIDTH-1:0] ADDR_TILES_IN = 4'h4;
  localparam logic [APB_ADDR_WIDTH-1:0] ADDR_MATS_OUT = 4'h8;

endpackage

/* verilog/tile_fifo.sv */
/*
  Tile FIFO
  Small register FIFO with valid/ready on both sides,
  deep enough for one column of tiles
*/
module tile_fifo (
  input  logic           clk,
  input  logic           rst,
  input  mtx_pkg::tile_t in_data,
  input  logic           in_valid,
  output logic           in_ready,
  output mtx_pkg::tile_t out_data,
  output logic           out_valid,
  input  logic           out_ready
);
  import mtx_pkg::*;

  tile_t                     mem [FIFO_DEPTH];
  logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
  logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
  logic [FIFO_CNT_WIDTH-1:0] count;
  logic                      push;
  logic                      pop;

  assign in_ready  = (count != FIFO_CNT_WIDTH'(FIFO_DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == FIFO_PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == FIFO_PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Occupancy only moves on a one-sided transfer
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_count_bound : assert property (@(posedge clk) disable iff (rst)
    count <= FIFO_CNT_WIDTH'(FIFO_DEPTH));

  // Head tile must not move while the consumer stalls
  a_head_hold : assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

/* verilog/stream_transpose.sv */
/*
  Streaming tile transpose
  Buffers input tiles per tile column, then reads the columns
  back as result rows and transposes each tile on the way out
*/
module stream_transpose (
  input  logic           clk,
  input  logic           rst,
  input  mtx_pkg::tile_t in_tile,
  input  logic           in_valid,
  output logic           in_ready,
  output mtx_pkg::tile_t out_tile,
  output logic           out_valid,
  input  logic           out_ready
);
  import mtx_pkg::*;

  // Tile position of the next input and output transfer
  logic [GRID_CNT_WIDTH-1:0] in_row;
  logic [GRID_CNT_WIDTH-1:0] in_col;
  logic [GRID_CNT_WIDTH-1:0] out_row;
  logic [GRID_CNT_WIDTH-1:0] out_col;

  logic [TILE_GRID-1:0] fifo_in_valid;
  logic [TILE_GRID-1:0] fifo_in_ready;
  logic [TILE_GRID-1:0] fifo_out_valid;
  logic [TILE_GRID-1:0] fifo_out_ready;
  tile_t                fifo_out_data [TILE_GRID];

  logic in_fire;
  logic out_fire;
  logic row_ok;

  function automatic tile_t transpose_tile(input tile_t t);
    tile_t r;
    for (int i = 0; i < TILE_DIM; i++) begin
      for (int j = 0; j < TILE_DIM; j++) begin
        r.e[j*TILE_DIM+i] = t.e[i*TILE_DIM+j];
      end
    end
    return r;
  endfunction

  // A result row starts only once its whole source column is buffered,
  // i.e. the column FIFO reports full
  assign row_ok = (out_col != '0) || !fifo_in_ready[out_row];

  for (genvar c = 0; c < TILE_GRID; c++) begin : g_col
    assign fifo_in_valid[c]  = in_valid && (in_col == GRID_CNT_WIDTH'(c));
    assign fifo_out_ready[c] = out_ready && row_ok && (out_row == GRID_CNT_WIDTH'(c));

    tile_fifo u_fifo (
      .clk      (clk),
      .rst      (rst),
      .in_data  (in_tile),
      .in_valid (fifo_in_valid[c]),
      .in_ready (fifo_in_ready[c]),
      .out_data (fifo_out_data[c]),
      .out_valid(fifo_out_valid[c]),
      .out_ready(fifo_out_ready[c])
    );
  end

  assign in_ready  = fifo_in_ready[in_col];
  assign out_valid = fifo_out_valid[out_row] && row_ok;
  assign out_tile  = transpose_tile(fifo_out_data[out_row]);

  assign in_fire  = in_valid && in_ready;
  assign out_fire = out_valid && out_ready;

  // Input walks row-major over the source tile grid
  always_ff @(posedge clk) begin
    if (rst) begin
      in_row <= '0;
      in_col <= '0;
    end else if (in_fire) begin
      if (in_col == GRID_LAST) begin
        in_col <= '0;
        in_row <= (in_row == GRID_LAST) ? '0 : in_row + 1'b1;
      end else begin
        in_col <= in_col + 1'b1;
      end
    end
  end

  // Output walks row-major over the result grid
  always_ff @(posedge clk) begin
    if (rst) begin
      out_row <= '0;
      out_col <= '0;
    end else if (out_fire) begin
      if (out_col == GRID_LAST) begin
        out_col <= '0;
        out_row <= (out_row == GRID_LAST) ? '0 : out_row + 1'b1;
      end else begin
        out_col <= out_col + 1'b1;
      end
    end
  end

  // Mid-row, the rest of the source column is still buffered
  a_row_buffered : assert property (@(posedge clk) disable iff (rst)
    (out_col != '0) |-> fifo_out_valid[out_row]);

  // Once offered, a result tile stays put until taken
  a_out_hold : assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_tile));

endmodule

/* verilog/tile_elem_op.sv */
/*
  Element operation stage
  Applies the configured opcode to all elements of a tile
  and holds the result in a one-deep output register
*/
module tile_elem_op (
  input  logic               clk,
  input  logic               rst,
  input  mtx_pkg::elem_cfg_t cfg,
  input  mtx_pkg::tile_t     in_tile,
  input  logic               in_valid,
  output logic               in_ready,
  output mtx_pkg::tile_t     out_tile,
  output logic               out_valid,
  input  logic               out_ready
);
  import mtx_pkg::*;

  tile_t op_tile;
  logic  in_fire;

  function automatic elem_t apply_op(input elem_t e, input elem_cfg_t c);
    elem_t r;
    case (c.op)
      OP_PASS: r = e;
      // Wraps, so the most negative value maps to itself
      OP_NEG:  r = -e;
      OP_SHR:  r = e >>> c.shamt;
      OP_ABS: begin
        if (e == ELEM_MIN) begin
          r = ELEM_MAX;
        end else begin
          r = (e < 0) ? -e : e;
        end
      end
      default: r = e;
    endcase
    return r;
  endfunction

  // All elements in parallel
  always_comb begin
    for (int i = 0; i < TILE_ELEMS; i++) begin
      op_tile.e[i] = apply_op(in_tile.e[i], cfg);
    end
  end

  // Accept when empty or when the held tile leaves this cycle
  assign in_ready = !out_valid || out_ready;
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_fire) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      out_tile <= op_tile;
    end
  end

  a_stall_hold : assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_tile));

endmodule

/* verilog/mtx_apb_regs.sv */
/*
  APB register block
  CTRL holds the element operation; TILES_IN and MATS_OUT
  count accepted input tiles and fully emitted matrices
*/
module mtx_apb_regs (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [mtx_pkg::APB_ADDR_WIDTH-1:0] paddr,
  input  logic [mtx_pkg::APB_DATA_WIDTH-1:0] pwdata,
  output logic [mtx_pkg::APB_DATA_WIDTH-1:0] prdata,
  output logic                               pready,
  output logic                               pslverr,
  input  logic                               in_fire,
  input  logic                               out_fire,
  output mtx_pkg::elem_cfg_t                 cfg
);
  import mtx_pkg::*;

  logic [STAT_WIDTH-1:0]     tiles_in;
  logic [STAT_WIDTH-1:0]     mats_out;
  logic [TILE_IDX_WIDTH-1:0] out_idx;
  logic                      access;
  logic                      addr_hit;
  logic                      addr_wr_ok;
  logic                      wr_ctrl;

  // No wait states
  assign pready = 1'b1;
  assign access = psel && penable;

  // Read data and address decode
  always_comb begin
    prdata     = '0;
    addr_hit   = 1'b1;
    addr_wr_ok = 1'b0;
    case (paddr)
      ADDR_CTRL: begin
        prdata[$bits(elem_cfg_t)-1:0] = cfg;
        addr_wr_ok = 1'b1;
      end
      ADDR_TILES_IN: prdata[STAT_WIDTH-1:0] = tiles_in;
      ADDR_MATS_OUT: prdata[STAT_WIDTH-1:0] = mats_out;
      default:       addr_hit = 1'b0;
    endcase
  end

  // Unmapped address or write to a status counter
  assign pslverr = access && (!addr_hit || (pwrite && !addr_wr_ok));
  assign wr_ctrl = access && pwrite && addr_wr_ok;

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg <= '{op: OP_PASS, shamt: '0};
    end else if (wr_ctrl) begin
      cfg <= elem_cfg_t'(pwdata[$bits(elem_cfg_t)-1:0]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tiles_in <= '0;
    end else if (in_fire) begin
      tiles_in <= tiles_in + 1'b1;
    end
  end

  // Matrix count bumps on the last tile of each result matrix
  always_ff @(posedge clk) begin
    if (rst) begin
      out_idx  <= '0;
      mats_out <= '0;
    end else if (out_fire) begin
      if (out_idx == TILE_IDX_WIDTH'(TILES_PER_MATRIX - 1)) begin
        out_idx  <= '0;
        mats_out <= mats_out + 1'b1;
      end else begin
        out_idx <= out_idx + 1'b1;
      end
    end
  end

  // Access phase always follows a setup phase
  a_apb_setup : assert property (@(posedge clk) disable iff (rst)
    psel && penable |-> $past(psel && !penable));

endmodule

/* verilog/mtx_top.sv */
/*
  Matrix transpose engine top
  Tile transpose stage feeding the element operation stage,
  with an APB block for the opcode and traffic counters
*/
module mtx_top (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [mtx_pkg::APB_ADDR_WIDTH-1:0] paddr,
  input  logic [mtx_pkg::APB_DATA_WIDTH-1:0] pwdata,
  output logic [mtx_pkg::APB_DATA_WIDTH-1:0] prdata,
  output logic                               pready,
  output logic                               pslverr,
  input  mtx_pkg::tile_t                     in_tile,
  input  logic                               in_valid,
  output logic                               in_ready,
  output mtx_pkg::tile_t                     out_tile,
  output logic                               out_valid,
  input  logic                               out_ready
);
  import mtx_pkg::*;

  tile_t     mid_tile;
  logic      mid_valid;
  logic      mid_ready;
  elem_cfg_t cfg;
  logic      in_fire;
  logic      out_fire;

  // Handshakes seen by the counters
  assign in_fire  = in_valid && in_ready;
  assign out_fire = out_valid && out_ready;

  stream_transpose u_transpose (
    .clk      (clk),
    .rst      (rst),
    .in_tile  (in_tile),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_tile (mid_tile),
    .out_valid(mid_valid),
    .out_ready(mid_ready)
  );

  tile_elem_op u_elem_op (
    .clk      (clk),
    .rst      (rst),
    .cfg      (cfg),
    .in_tile  (mid_tile),
    .in_valid (mid_valid),
    .in_ready (mid_ready),
    .out_tile (out_tile),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

  mtx_apb_regs u_regs (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .in_fire (in_fire),
    .out_fire(out_fire),
    .cfg     (cfg)
  );

endmodule

/* bench/mtx_tb.sv */
/*
  Matrix transpose engine testbench
  Streams random matrices through the DUT, checks every output
  tile against a queue-based reference and exercises the APB registers
*/
module mtx_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import mtx_pkg::*;

  localparam int STREAM_LIMIT = 2000;
  localparam int APB_LIMIT    = 16;

  logic                      clk;
  logic                      rst;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [APB_ADDR_WIDTH-1:0] paddr;
  logic [APB_DATA_WIDTH-1:0] pwdata;
  logic [APB_DATA_WIDTH-1:0] prdata;
  logic                      pready;
  logic                      pslverr;
  tile_t                     in_tile;
  logic                      in_valid;
  logic                      in_ready;
  tile_t                     out_tile;
  logic                      out_valid;
  logic                      out_ready;

  // Reference model and run bookkeeping
  logic [31:0] lfsr = 32'hb62617a2;
  tile_t       in_q [$];
  tile_t       exp_q [$];
  tile_t       exp_head;
  logic        exp_avail;
  elem_cfg_t   cur_cfg;
  string       test_name;
  int          errors;
  int          err_base;
  int          tests_run;
  int          tests_failed;
  int          mats_sent;
  bit          stop_run;

  mtx_top dut (
    .clk      (clk),
    .rst      (rst),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .in_tile  (in_tile),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_tile (out_tile),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic void refresh_head();
    exp_avail = (exp_q.size() != 0);
    exp_head  = exp_avail ? exp_q[0] : '0;
  endfunction

  // Expected element value straight from the opcode definitions
  function automatic int expect_elem(input int v, input elem_cfg_t c);
    int r;
    int d;
    r = v;
    case (c.op)
      OP_NEG: begin
        r = -v;
        if (r > int'(ELEM_MAX)) r = r - (1 << DATA_WIDTH);
      end
      OP_SHR: begin
        d = 1 << c.shamt;
        // Arithmetic shift rounds toward minus infinity
        r = (v >= 0) ? v / d : -((-v + d - 1) / d);
      end
      OP_ABS: begin
        r = (v < 0) ? -v : v;
        if (r > int'(ELEM_MAX)) r = int'(ELEM_MAX);
      end
      default: r = v;
    endcase
    return r;
  endfunction

  // Random matrix, split into input tiles plus the expected result tiles
  task automatic queue_matrix(input bit edge_vals);
    elem_t m [TOTAL_DIM][TOTAL_DIM];
    tile_t t;
    for (int r = 0; r < TOTAL_DIM; r++) begin
      for (int c = 0; c < TOTAL_DIM; c++) begin
        m[r][c] = elem_t'(rand_bits(DATA_WIDTH));
      end
    end
    if (edge_vals) begin
      m[0][0] = ELEM_MIN;
      m[1][2] = ELEM_MAX;
      m[3][1] = ELEM_MIN;
    end
    for (int tr = 0; tr < TILE_GRID; tr++) begin
      for (int tc = 0; tc < TILE_GRID; tc++) begin
        for (int a = 0; a < TILE_DIM; a++) begin
          for (int b = 0; b < TILE_DIM; b++) begin
            t.e[a*TILE_DIM+b] = m[tr*TILE_DIM+a][tc*TILE_DIM+b];
          end
        end
        in_q.push_back(t);
      end
    end
    // Result element (i, j) is source element (j, i)
    for (int rr = 0; rr < TILE_GRID; rr++) begin
      for (int rc = 0; rc < TILE_GRID; rc++) begin
        for (int a = 0; a < TILE_DIM; a++) begin
          for (int b = 0; b < TILE_DIM; b++) begin
            t.e[a*TILE_DIM+b] = elem_t'(expect_elem(
              int'(m[rc*TILE_DIM+b][rr*TILE_DIM+a]), cur_cfg));
          end
        end
        exp_q.push_back(t);
      end
    end
    refresh_head();
    mats_sent++;
  endtask

  // Drives queued tiles and takes results until both queues are empty
  task automatic stream_tiles(input bit gaps);
    int cycles;
    bit offering;
    if (stop_run) return;
    cycles   = 0;
    offering = 1'b0;
    while ((in_q.size() != 0 || exp_q.size() != 0) && cycles < STREAM_LIMIT) begin
      @(posedge clk);
      cycles++;
      if (offering && in_ready) begin
        void'(in_q.pop_front());
        offering = 1'b0;
      end
      if (!offering && in_q.size() != 0 && (!gaps || rand_bits(2) != 0)) begin
        in_tile  <= in_q[0];
        offering = 1'b1;
      end
      in_valid  <= offering;
      out_ready <= gaps ? (rand_bits(1) != 0) : 1'b1;
    end
    in_valid  <= 1'b0;
    out_ready <= 1'b1;
    if (in_q.size() != 0 || exp_q.size() != 0) begin
      $display("%s: stream timed out with %0d tiles unsent and %0d results missing",
               test_name, in_q.size(), exp_q.size());
      errors++;
      stop_run = 1'b1;
    end
  endtask

  task automatic apb_access(input logic wr, input logic [APB_ADDR_WIDTH-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waits;
    rdata = '0;
    err   = 1'b0;
    if (stop_run) return;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    waits = 0;
    do begin
      @(posedge clk);
      waits++;
    end while (!pready && waits < APB_LIMIT);
    if (!pready) begin
      $display("%s: APB access to %h never completed", test_name, addr);
      errors++;
      stop_run = 1'b1;
    end
    rdata = prdata;
    err   = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic check_reg(input logic [APB_ADDR_WIDTH-1:0] addr,
                           input logic [31:0] expected);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b0, addr, '0, rd, err);
    assert (!err) else begin
      $display("%s: read of address %h raised pslverr", test_name, addr);
      errors++;
    end
    assert (rd == expected) else begin
      $display("[FAIL] %s: expected %h, actual %h", test_name, expected, rd);
      errors++;
    end
  endtask

  task automatic write_ctrl(input elem_op_e op, input int shamt);
    logic [31:0] rd;
    logic        err;
    cur_cfg = '{op: op, shamt: SHAMT_WIDTH'(shamt)};
    apb_access(1'b1, ADDR_CTRL, 32'(cur_cfg), rd, err);
    assert (!err) else begin
      $display("%s: write of CTRL raised pslverr", test_name);
      errors++;
    end
    check_reg(ADDR_CTRL, 32'(cur_cfg));
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_base  = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != err_base) tests_failed++;
    $display("test %s: %s (%0d errors)", test_name,
             (errors == err_base) ? "passed" : "failed", errors - err_base);
  endtask

  // Pipeline idle, so the new opcode applies to the whole next matrix
  task automatic op_test(input string name, input elem_op_e op, input int shamt);
    begin_test(name);
    write_ctrl(op, shamt);
    queue_matrix(1'b1);
    queue_matrix(1'b0);
    stream_tiles(1'b1);
    end_test();
  endtask

  // Result tiles leave the DUT in reference order
  always @(posedge clk) begin
    if (!rst && out_valid && out_ready && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
      refresh_head();
    end
  end

  a_out_expected : assert property (@(posedge clk) disable iff (rst)
    out_valid && out_ready |-> exp_avail)
    else begin
      $display("%s: output tile %h arrived with no result pending",
               test_name, $sampled(out_tile));
      errors++;
    end

  a_out_value : assert property (@(posedge clk) disable iff (rst)
    out_valid && out_ready && exp_avail |-> out_tile == exp_head)
    else begin
      $display("[FAIL] %s: expected %h, actual %h",
               test_name, $sampled(exp_head), $sampled(out_tile));
      errors++;
    end

  initial begin
    logic [31:0] rd;
    logic        err;
    rst       = 1'b1;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    in_tile   = '0;
    in_valid  = 1'b0;
    out_ready = 1'b1;
    cur_cfg   = '{op: OP_PASS, shamt: '0};
    refresh_head();
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    begin_test("reset");
    @(posedge clk);
    assert (!out_valid && !pslverr) else begin
      $display("[FAIL] %s: expected 00, actual %b%b", test_name, out_valid, pslverr);
      errors++;
    end
    check_reg(ADDR_CTRL, '0);
    check_reg(ADDR_TILES_IN, '0);
    check_reg(ADDR_MATS_OUT, '0);
    end_test();

    begin_test("pass_stream");
    repeat (3) queue_matrix(1'b0);
    stream_tiles(1'b0);
    end_test();

    begin_test("backpressure");
    repeat (3) queue_matrix(1'b0);
    stream_tiles(1'b1);
    end_test();

    op_test("op_neg", OP_NEG, 0);
    op_test("op_shr", OP_SHR, 3);
    op_test("op_abs", OP_ABS, 0);

    begin_test("counters");
    check_reg(ADDR_TILES_IN, 32'(mats_sent * TILES_PER_MATRIX));
    check_reg(ADDR_MATS_OUT, 32'(mats_sent));
    end_test();

    begin_test("apb_errors");
    apb_access(1'b0, 4'hc, '0, rd, err);
    assert (err) else begin
      $display("%s: read of unmapped address 0xC gave no pslverr", test_name);
      errors++;
    end
    apb_access(1'b1, ADDR_TILES_IN, 32'h0000_55aa, rd, err);
    assert (err) else begin
      $display("%s: write to TILES_IN gave no pslverr", test_name);
      errors++;
    end
    check_reg(ADDR_TILES_IN, 32'(mats_sent * TILES_PER_MATRIX));
    check_reg(ADDR_CTRL, 32'(cur_cfg));
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* compile.f */
verilog/mtx_pkg.sv
verilog/tile_fifo.sv
verilog/stream_transpose.sv
verilog/tile_elem_op.sv
verilog/mtx_apb_regs.sv
verilog/mtx_top.sv
bench/mtx_tb.sv

/* Bender.yml */
package:
  name: mtx_transpose

sources:
  - files:
      - verilog/mtx_pkg.sv
      - verilog/tile_fifo.sv
      - verilog/stream_transpose.sv
      - verilog/tile_elem_op.sv
      - verilog/mtx_apb_regs.sv
      - verilog/mtx_top.sv
  - target: test
    files:
      - bench/mtx_tb.sv
